/* core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define SLOTS       4           // Clock slots per machine cycle.
`define RESET_PC    16'h0000    // First fetch address.

`define OP_NOP      8'h00       // No operation.
`define OP_HALT     8'h76       // Sleep until wake.
`define OP_LD_HL_A  8'h77       // Store A at (HL).
`define OP_JP       8'hC3       // Absolute jump.
`define OP_JPZ      8'hCA       // Jump when Z set.

`define REG_B       3'd0        // Register field codes, SM83 order.
`define REG_C       3'd1
`define REG_D       3'd2
`define REG_E       3'd3
`define REG_H       3'd4
`define REG_L       3'd5
`define REG_MEM     3'd6        // The (HL) operand slot.
`define REG_A       3'd7

`define GRP_MISC    2'b00       // Opcode bits [7:6].
`define GRP_LD      2'b01
`define GRP_ALU     2'b10

`define LO_INC      3'b100      // 00rrr100.
`define LO_LD_N     3'b110      // 00rrr110.

`define ALU_F_ADD   3'b000      // ooo field of the 10 group.
`define ALU_F_SUB   3'b010
`define ALU_F_AND   3'b100
`define ALU_F_XOR   3'b101

`endif

/* sm83Pkg.sv */
package sm83Pkg;

`include "core_consts.svh"

	// Register select, same encoding as the opcode fields.
	typedef enum logic [2:0] {
		regB   = `REG_B,
		regC   = `REG_C,
		regD   = `REG_D,
		regE   = `REG_E,
		regH   = `REG_H,
		regL   = `REG_L,
		regMem = `REG_MEM,	// Immediate byte when used as a source.
		regA   = `REG_A
	} regSel;

	typedef enum logic [2:0] {
		aluPass,			// Result is operand B.
		aluAdd,
		aluSub,
		aluAnd,
		aluXor,
		aluInc				// Operand A plus one, carry kept.
	} aluOp;

	typedef enum logic [1:0] {
		stFetch,			// Opcode read, previous op completes.
		stExec,				// Operand read or store.
		stHalted			// Bus idle.
	} mState;

	typedef struct packed {
		aluOp       op;
		regSel      src;
		regSel      dst;
		logic       writeReg;	// Write dst on the strobe.
		logic       writeFlags;	// Update ZNHC on the strobe.
		logic       useImm;		// Operand read from PC.
		logic       memWrite;	// Store cycle at HL.
		logic       jump;		// Load PC this cycle.
		logic       condZ;		// Jump only if Z.
		logic [1:0] mCycles;	// Machine cycles incl. fetch.
	} decodedOp;

endpackage

/* ctrlIf.sv */
`timescale 1ns/100ps

interface ctrlIf;
	import sm83Pkg::*;

	decodedOp   dec;			// Decoded control for the current cycle.
	logic [1:0] mCycle;			// Cycle index of the op in IR.
	logic       execStrobe;		// T3 pulse, commits the cycle.
	logic       latchData;		// T1 pulse, samples the data bus.

	modport decoder (
		input  mCycle,
		output dec
	);

	modport sequencer (
		input  dec,
		output mCycle,
		output execStrobe,
		output latchData
	);

	modport datapath (
		input  dec,
		input  mCycle,
		input  execStrobe,
		input  latchData
	);

endinterface

/* Sequencer.sv */
`timescale 1ns/100ps
`include "core_consts.svh"

module Sequencer (
	input  logic       CLK,
	input  logic       reset,
	input  logic       wake,
	input  logic [7:0] dataLatch,		// Fetched opcode.
	ctrlIf.sequencer   ctrl,
	output logic [7:0] irOut,
	output logic       rd,
	output logic       wr,
	output logic       mreq,
	output logic       loadIr
);
	import sm83Pkg::*;

	localparam int SlotBits = $clog2(`SLOTS);
	localparam logic [SlotBits-1:0] LastSlot = SlotBits'(`SLOTS - 1);

	logic [SlotBits-1:0] slot;		// T0..T3.
	logic [1:0]          mCycle;	// Counts 1..mCycles after a fetch.
	logic                halted;
	logic                coldStart;	// Leave HALTED once after reset.
	logic [7:0]          ir;
	mState               cycleKind;
	logic                busSlot;	// T0 or T1.
	logic                endSlot;	// T3.

	assign busSlot = (slot < SlotBits'(2));
	assign endSlot = (slot == LastSlot);

	// Once mCycle reaches the length of the op in IR, this cycle fetches the next one.
	always_comb begin
		if (halted) begin
			cycleKind = stHalted;
		end else if (mCycle >= ctrl.dec.mCycles) begin
			cycleKind = stFetch;
		end else begin
			cycleKind = stExec;
		end
	end

	assign rd = busSlot && ((cycleKind == stFetch) ||
		(cycleKind == stExec && ctrl.dec.useImm));			// Opcode or operand.
	assign wr = busSlot && (cycleKind == stExec) && ctrl.dec.memWrite;
	assign mreq = rd || wr;									// Any bus access.
	assign loadIr = endSlot && (cycleKind == stFetch);		// IR loads at this edge.

	assign irOut = ir;
	assign ctrl.mCycle = mCycle;
	assign ctrl.execStrobe = endSlot && !halted;
	assign ctrl.latchData = (slot == SlotBits'(1)) && !halted;	// End of T1.

	always_ff @(posedge CLK) begin
		if (reset) begin
			slot <= '0;
			mCycle <= 2'd1;					// IR holds NOP, so first cycle fetches.
			halted <= 1'b1;					// Idle for one cycle.
			coldStart <= 1'b1;
			ir <= `OP_NOP;
		end else if (halted) begin
			if (wake || coldStart) begin	// Slot is already T0 here.
				halted <= 1'b0;
				coldStart <= 1'b0;
			end
		end else begin
			slot <= endSlot ? '0 : slot + 1'b1;
			if (endSlot) begin
				if (cycleKind == stFetch) begin
					ir <= dataLatch;		// New op, old one just committed.
					mCycle <= 2'd1;
					halted <= (dataLatch == `OP_HALT);	// PC already past HALT.
				end else begin
					mCycle <= mCycle + 2'd1;
				end
			end
		end
	end

endmodule

/* Decoder.sv */
`timescale 1ns/100ps
`include "core_consts.svh"

module Decoder (
	input  logic [7:0] irOut,
	ctrlIf.decoder     ctrl
);
	import sm83Pkg::*;

	decodedOp   base;			// Opcode decode, not yet tied to a cycle.
	decodedOp   qual;			// Per-cycle control.
	logic [1:0] grp;
	logic [2:0] hi;
	logic [2:0] lo;
	logic       execCycle;		// Last cycle, overlapped with next fetch.

	assign grp = irOut[7:6];
	assign hi  = irOut[5:3];
	assign lo  = irOut[2:0];

	always_comb begin
		base = '0;
		base.op = aluPass;
		base.src = regB;
		base.dst = regB;
		base.mCycles = 2'd1;				// NOP shape unless matched.
		case (irOut)
			`OP_NOP, `OP_HALT: begin
				base.mCycles = 2'd1;		// Sequencer handles HALT itself.
			end
			`OP_LD_HL_A: begin
				base.src = regA;
				base.memWrite = 1'b1;
				base.mCycles = 2'd2;
			end
			`OP_JP, `OP_JPZ: begin
				base.useImm = 1'b1;			// Low byte, then high byte.
				base.jump = 1'b1;
				base.condZ = (irOut == `OP_JPZ);
				base.mCycles = 2'd3;
			end
			default: begin
				if (grp == `GRP_MISC && lo == `LO_LD_N && hi != `REG_MEM) begin
					base.dst = regSel'(hi);
					base.src = regMem;		// Immediate latch as source.
					base.writeReg = 1'b1;
					base.useImm = 1'b1;
					base.mCycles = 2'd2;
				end else if (grp == `GRP_MISC && lo == `LO_INC && hi != `REG_MEM) begin
					base.op = aluInc;
					base.dst = regSel'(hi);
					base.writeReg = 1'b1;
					base.writeFlags = 1'b1;
				end else if (grp == `GRP_LD && hi != `REG_MEM && lo != `REG_MEM) begin
					base.dst = regSel'(hi);	// LD r,r'.
					base.src = regSel'(lo);
					base.writeReg = 1'b1;
				end else if (grp == `GRP_ALU && lo != `REG_MEM) begin
					base.dst = regA;
					base.src = regSel'(lo);
					base.writeReg = 1'b1;
					base.writeFlags = 1'b1;
					case (hi)
						`ALU_F_ADD: base.op = aluAdd;
						`ALU_F_SUB: base.op = aluSub;
						`ALU_F_AND: base.op = aluAnd;
						`ALU_F_XOR: base.op = aluXor;
						default: begin		// ADC, SBC, OR, CP not built.
							base.writeReg = 1'b0;
							base.writeFlags = 1'b0;
						end
					endcase
				end
			end
		endcase
	end

	assign execCycle = (ctrl.mCycle >= base.mCycles);

	always_comb begin
		qual = base;
		qual.writeReg = base.writeReg && execCycle;
		qual.writeFlags = base.writeFlags && execCycle;
		qual.useImm = base.useImm && !execCycle;		// Operand cycles only.
		qual.memWrite = base.memWrite && !execCycle;
		qual.jump = base.jump && (ctrl.mCycle == 2'd2);	// High byte cycle.
	end

	assign ctrl.dec = qual;

endmodule

/* Alu.sv */
`timescale 1ns/100ps

module Alu (
	input  logic       CLK,
	input  logic       reset,
	ctrlIf.datapath    ctrl,
	input  logic [7:0] opA,			// Destination register.
	input  logic [7:0] opB,			// Source register or immediate.
	output logic [7:0] aluRes,
	output logic       flagZ
);
	import sm83Pkg::*;

	logic [3:0] flags;				// Z N H C.
	logic [8:0] sum;				// Bit 8 is carry or borrow.
	logic [4:0] half;				// Bit 4 is half carry or borrow.
	logic       nextN;
	logic       nextH;
	logic       nextC;

	always_comb begin
		sum = '0;
		half = '0;
		aluRes = opB;				// PASS.
		nextN = 1'b0;
		nextH = 1'b0;
		nextC = flags[0];
		case (ctrl.dec.op)
			aluAdd: begin
				sum = {1'b0, opA} + {1'b0, opB};
				half = {1'b0, opA[3:0]} + {1'b0, opB[3:0]};
				aluRes = sum[7:0];
				nextH = half[4];
				nextC = sum[8];
			end
			aluSub: begin
				sum = {1'b0, opA} - {1'b0, opB};
				half = {1'b0, opA[3:0]} - {1'b0, opB[3:0]};
				aluRes = sum[7:0];
				nextN = 1'b1;
				nextH = half[4];	// Borrow from bit 4.
				nextC = sum[8];
			end
			aluAnd: begin
				aluRes = opA & opB;
				nextH = 1'b1;		// SM83 sets H on AND.
				nextC = 1'b0;
			end
			aluXor: begin
				aluRes = opA ^ opB;
				nextC = 1'b0;
			end
			aluInc: begin
				sum = {1'b0, opA} + 9'd1;
				half = {1'b0, opA[3:0]} + 5'd1;
				aluRes = sum[7:0];
				nextH = half[4];	// C left alone.
			end
			default: aluRes = opB;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (ctrl.execStrobe && ctrl.dec.writeFlags) begin
			flags <= {(aluRes == 8'h00), nextN, nextH, nextC};
		end
	end

	assign flagZ = flags[3];		// Read by JP Z.

endmodule

/* Bottom.sv */
`timescale 1ns/100ps
`include "core_consts.svh"

module Bottom (
	input  logic        CLK,
	input  logic        reset,
	ctrlIf.datapath     ctrl,
	input  logic [7:0]  dataIn,
	input  logic [7:0]  aluRes,
	input  logic        flagZ,
	output logic [7:0]  opA,
	output logic [7:0]  opB,
	output logic [7:0]  dataLatch,
	output logic [15:0] addr,
	output logic [7:0]  dataOut
);
	import sm83Pkg::*;

	logic [7:0]  regs [8];			// Indexed by regSel, slot 6 unused.
	logic [15:0] pc;
	logic [7:0]  immLatch;			// LD r,n operand.
	logic [7:0]  jpLow;				// JP target low byte.
	logic        fetchCycle;
	logic        advancePc;
	logic        takeJump;

	assign fetchCycle = (ctrl.mCycle >= ctrl.dec.mCycles);
	assign advancePc = fetchCycle || ctrl.dec.useImm;	// Every byte read from PC.
	assign takeJump = ctrl.dec.jump && (!ctrl.dec.condZ || flagZ);

	assign opA = regs[ctrl.dec.dst];
	assign opB = (ctrl.dec.src == regMem) ? immLatch : regs[ctrl.dec.src];

	// Address mux, HL only during the store cycle.
	assign addr = ctrl.dec.memWrite ? {regs[regH], regs[regL]} : pc;
	assign dataOut = regs[regA];	// Only A is ever stored.

	always_ff @(posedge CLK) begin
		if (ctrl.latchData) begin
			dataLatch <= dataIn;	// Memory answers by T1.
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.execStrobe && ctrl.dec.useImm) begin
			immLatch <= dataLatch;
			if (ctrl.mCycle == 2'd1) begin
				jpLow <= dataLatch;	// First operand byte.
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (ctrl.execStrobe && ctrl.dec.writeReg) begin
			regs[ctrl.dec.dst] <= aluRes;	// Write-back in the next fetch's T3.
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (ctrl.execStrobe) begin
			if (takeJump) begin
				pc <= {dataLatch, jpLow};	// High byte still in the latch.
			end else if (advancePc) begin
				pc <= pc + 16'd1;
			end
		end
	end

endmodule

/* SM83Core.sv */
`timescale 1ns/100ps

module SM83Core (
	input  logic        CLK,
	input  logic        reset,
	input  logic        wake,		// Leaves HALT.
	input  logic [7:0]  dataIn,
	output logic [15:0] addr,
	output logic [7:0]  dataOut,
	output logic        rd,
	output logic        wr,
	output logic        mreq,
	output logic        loadIr		// Opcode fetch marker.
);

	logic [7:0] irOut;
	logic [7:0] aluRes;
	logic       flagZ;
	logic [7:0] opA;
	logic [7:0] opB;
	logic [7:0] dataLatch;

	ctrlIf ctrl ();					// Decoded control and cycle timing.

	Sequencer seq (
		.CLK(CLK),
		.reset(reset),
		.wake(wake),
		.dataLatch(dataLatch),
		.ctrl(ctrl.sequencer),
		.irOut(irOut),
		.rd(rd),
		.wr(wr),
		.mreq(mreq),
		.loadIr(loadIr) );

	Decoder dec (
		.irOut(irOut),
		.ctrl(ctrl.decoder) );

	Alu alu (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.opA(opA),
		.opB(opB),
		.aluRes(aluRes),
		.flagZ(flagZ) );

	Bottom bot (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.dataIn(dataIn),
		.aluRes(aluRes),
		.flagZ(flagZ),
		.opA(opA),
		.opB(opB),
		.dataLatch(dataLatch),
		.addr(addr),
		.dataOut(dataOut) );

endmodule

/* tbClock.sv */
`timescale 1ns/100ps

module tbClock (
	output logic CLK,
	output logic porReset		// Power-on reset, high for the first cycles.
);
	localparam realtime HalfPeriod = 4ns;	// 8 ns period.
	localparam int ResetCycles = 5;

	initial begin
		CLK = 1'b0;
		forever #(HalfPeriod) CLK = ~CLK;
	end

	initial begin
		porReset = 1'b1;
		repeat (ResetCycles) @(posedge CLK);
		porReset <= 1'b0;			// Released on a rising edge.
	end

endmodule

/* SM83CoreTb.sv */
`timescale 1ns/100ps
`include "core_consts.svh"

module SM83CoreTb;

	localparam int TimeoutCycles = 20000;	// About ten times the summed program runs.

	logic        CLK;
	logic        porReset;
	logic        tbReset = 1'b0;		// Per-test reset pulse.
	logic        reset;
	logic        wake = 1'b0;
	logic [7:0]  dataIn = 8'h00;
	logic [15:0] addr;
	logic [7:0]  dataOut;
	logic        rd;
	logic        wr;
	logic        mreq;
	logic        loadIr;

	logic [7:0]  mem [65536];			// Flat 64 KB memory.
	logic [15:0] cursor;				// Program assembly address.
	logic [15:0] writeAddrs [$];		// Stores seen on the bus.
	logic [7:0]  writeData [$];
	logic [15:0] expAddrs [$];			// Stores the program should make.
	logic [7:0]  expData [$];
	logic [15:0] fetchLog [$];			// Opcode fetch addresses in order.
	logic        wrSeen = 1'b0;
	logic [15:0] lfsr = 16'd42;
	int          cycles = 0;
	int          errors = 0;
	int          checks = 0;

	assign reset = porReset || tbReset;

	tbClock clkGen (
		.CLK(CLK),
		.porReset(porReset) );

	SM83Core i_SM83Core (
		.CLK(CLK),
		.reset(reset),
		.wake(wake),
		.dataIn(dataIn),
		.addr(addr),
		.dataOut(dataOut),
		.rd(rd),
		.wr(wr),
		.mreq(mreq),
		.loadIr(loadIr) );

	// Memory model sampled on the rising edge.
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (rd) begin
			dataIn <= mem[addr];			// Valid before the T1 latch edge.
		end
		if (wr && !wrSeen) begin			// One record per store cycle.
			checks++;
			if (mreq !== 1'b1) reportMismatch("mreq", 16'(mreq), 16'h0001);
			writeAddrs.push_back(addr);
			writeData.push_back(dataOut);
			mem[addr] = dataOut;
		end
		wrSeen = wr;
		if (loadIr) begin
			fetchLog.push_back(addr);		// PC of the fetched opcode.
		end
	end

	initial begin
		while (cycles < TimeoutCycles) @(posedge CLK);
		errors++;
		$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("TEST FAIL");
		$finish;
	end

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		lfsrNext = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);	// Galois form of x^16+x^14+x^13+x^11+1.
	endfunction

	task automatic randByte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};		// One step per bit.
			lfsr = lfsrNext(lfsr);
		end
	endtask

	task automatic reportMismatch(input string sig, input logic [15:0] got,
		input logic [15:0] exp);
		$display("ERROR at %0t ns: %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic clearMemory();
		for (int a = 0; a < 65536; a++) begin
			mem[a] = a[15:8] ^ a[7:0] ^ 8'h5A;	// Pattern from the whole address.
		end
		cursor = 16'h0000;
		writeAddrs.delete();
		writeData.delete();
		expAddrs.delete();
		expData.delete();
		fetchLog.delete();
	endtask

	task automatic putByte(input logic [7:0] b);
		mem[cursor] = b;
		cursor = cursor + 16'd1;
	endtask

	task automatic ldImm(input logic [2:0] r, input logic [7:0] n);
		putByte({2'b00, r, `LO_LD_N});		// LD r,n.
		putByte(n);
	endtask

	task automatic ldReg(input logic [2:0] d, input logic [2:0] s);
		putByte({2'b01, d, s});				// LD d,s.
	endtask

	task automatic aluWith(input logic [2:0] f, input logic [2:0] s);
		putByte({2'b10, f, s});				// A = A op s.
	endtask

	task automatic incReg(input logic [2:0] r);
		putByte({2'b00, r, `LO_INC});
	endtask

	task automatic storeA(input logic [15:0] where);
		ldImm(`REG_H, where[15:8]);
		ldImm(`REG_L, where[7:0]);
		putByte(`OP_LD_HL_A);
	endtask

	task automatic jumpTo(input logic cond, input logic [15:0] target);
		putByte(cond ? `OP_JPZ : `OP_JP);
		putByte(target[7:0]);				// Low byte first.
		putByte(target[15:8]);
	endtask

	task automatic expectWrite(input logic [15:0] where, input logic [7:0] value);
		expAddrs.push_back(where);
		expData.push_back(value);
	endtask

	task automatic pulseReset();
		@(posedge CLK);
		tbReset <= 1'b1;
		repeat (5) @(posedge CLK);
		tbReset <= 1'b0;
	endtask

	task automatic runUntilHalt();
		@(negedge CLK);
		while (!(loadIr === 1'b1 && mem[addr] == `OP_HALT)) @(negedge CLK);
		@(posedge CLK);						// HALT enters IR here.
	endtask

	task automatic strobesIdle();
		checks++;
		if (rd !== 1'b0) reportMismatch("rd", 16'(rd), 16'h0000);
		if (wr !== 1'b0) reportMismatch("wr", 16'(wr), 16'h0000);
		if (mreq !== 1'b0) reportMismatch("mreq", 16'(mreq), 16'h0000);
		if (loadIr !== 1'b0) reportMismatch("loadIr", 16'(loadIr), 16'h0000);
	endtask

	task automatic compareWrites();
		checks++;
		if (writeAddrs.size() != expAddrs.size()) begin
			$display("Store count wrong at %0t ns: saw %0d, wanted %0d", $time,
				writeAddrs.size(), expAddrs.size());
			errors++;
		end
		for (int i = 0; i < expAddrs.size() && i < writeAddrs.size(); i++) begin
			checks++;
			if (writeAddrs[i] !== expAddrs[i]) reportMismatch("addr", writeAddrs[i], expAddrs[i]);
			if (writeData[i] !== expData[i]) reportMismatch("dataOut", 16'(writeData[i]),
				16'(expData[i]));
		end
	endtask

	task automatic checkNextFetch(input logic [15:0] from, input logic [15:0] expected);
		logic found;
		found = 1'b0;
		checks++;
		for (int i = 0; i + 1 < fetchLog.size(); i++) begin
			if (!found && fetchLog[i] == from) begin
				found = 1'b1;
				if (fetchLog[i+1] !== expected) reportMismatch("fetch addr", fetchLog[i+1], expected);
			end
		end
		if (!found) begin
			$display("No fetch followed the opcode at %h", from);
			errors++;
		end
	endtask

	task automatic checkReset();
		logic sawLoad;
		clearMemory();
		putByte(`OP_NOP);
		putByte(`OP_HALT);
		@(posedge CLK);
		wake <= 1'b1;						// Core busy on the bus when reset hits.
		@(posedge CLK);
		wake <= 1'b0;
		@(posedge CLK);
		tbReset <= 1'b1;
		@(posedge CLK);						// Core takes reset on this edge.
		repeat (4) begin
			@(negedge CLK);
			strobesIdle();
			@(posedge CLK);
		end
		tbReset <= 1'b0;
		@(negedge CLK);
		strobesIdle();						// First cycle after release.
		@(negedge CLK);
		checks++;
		if (rd !== 1'b1) reportMismatch("rd", 16'(rd), 16'h0001);
		if (mreq !== 1'b1) reportMismatch("mreq", 16'(mreq), 16'h0001);
		if (addr !== `RESET_PC) reportMismatch("addr", addr, `RESET_PC);
		sawLoad = 1'b0;
		repeat (3) begin
			@(negedge CLK);
			if (loadIr === 1'b1) sawLoad = 1'b1;
		end
		if (!sawLoad) begin
			$display("loadIr did not pulse in the first machine cycle");
			errors++;
		end
		runUntilHalt();
	endtask

	task automatic loadsAndStores();
		logic [7:0] n;
		clearMemory();
		for (int i = 0; i < 8; i++) begin
			if (i != 6) begin				// Code 6 is the (HL) slot.
				randByte(n);
				ldImm(3'(i), n);
				ldReg(`REG_A, 3'(i));
				storeA(16'h8000 + 16'(i));
				expectWrite(16'h8000 + 16'(i), n);
			end
		end
		randByte(n);
		ldImm(`REG_B, n);					// Pass one value through every register.
		ldReg(`REG_C, `REG_B);
		ldReg(`REG_D, `REG_C);
		ldReg(`REG_E, `REG_D);
		ldReg(`REG_H, `REG_E);
		ldReg(`REG_L, `REG_H);
		ldReg(`REG_A, `REG_L);
		storeA(16'h8010);
		expectWrite(16'h8010, n);
		putByte(`OP_HALT);
		pulseReset();
		runUntilHalt();
		compareWrites();
	endtask

	task automatic aluOps();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] expected;
		logic [2:0] src;
		clearMemory();
		for (int k = 0; k < 15; k++) begin
			randByte(a);
			randByte(b);
			src = 3'(k % 4);				// B, C, D, E in turn.
			ldImm(`REG_A, a);
			ldImm(src, b);
			case (k % 5)
				0: begin
					aluWith(`ALU_F_ADD, src);
					expected = a + b;		// Carry out dropped.
				end
				1: begin
					aluWith(`ALU_F_SUB, src);
					expected = a - b;
				end
				2: begin
					aluWith(`ALU_F_AND, src);
					expected = a & b;
				end
				3: begin
					aluWith(`ALU_F_XOR, src);
					expected = a ^ b;
				end
				default: begin
					incReg(src);
					ldReg(`REG_A, src);
					expected = b + 8'd1;
				end
			endcase
			storeA(16'h8100 + 16'(k));
			expectWrite(16'h8100 + 16'(k), expected);
		end
		putByte(`OP_HALT);
		pulseReset();
		runUntilHalt();
		compareWrites();
	endtask

	task automatic jumps();
		logic [15:0] jpAt;
		logic [15:0] takenAt;
		logic [15:0] skipAt;
		clearMemory();
		ldImm(`REG_A, 8'h11);
		jpAt = cursor;
		jumpTo(1'b0, 16'h0120);
		ldImm(`REG_A, 8'hEE);				// Skipped by the jump.
		putByte(`OP_HALT);
		cursor = 16'h0120;
		storeA(16'h8200);
		expectWrite(16'h8200, 8'h11);
		ldImm(`REG_A, 8'h37);
		ldImm(`REG_B, 8'h37);
		aluWith(`ALU_F_SUB, `REG_B);		// Zero result sets Z.
		takenAt = cursor;
		jumpTo(1'b1, 16'h0180);
		ldImm(`REG_A, 8'hBB);
		storeA(16'h8201);
		putByte(`OP_HALT);
		cursor = 16'h0180;
		ldImm(`REG_A, 8'hAA);
		storeA(16'h8201);
		expectWrite(16'h8201, 8'hAA);
		ldImm(`REG_A, 8'h37);
		ldImm(`REG_B, 8'h12);
		aluWith(`ALU_F_SUB, `REG_B);		// Nonzero result clears Z.
		skipAt = cursor;
		jumpTo(1'b1, 16'h01C0);
		ldImm(`REG_A, 8'hCC);
		storeA(16'h8202);
		expectWrite(16'h8202, 8'hCC);
		putByte(`OP_HALT);
		cursor = 16'h01C0;
		ldImm(`REG_A, 8'hDD);
		storeA(16'h8202);
		putByte(`OP_HALT);
		pulseReset();
		runUntilHalt();
		compareWrites();
		checkNextFetch(jpAt, 16'h0120);
		checkNextFetch(takenAt, 16'h0180);
		checkNextFetch(skipAt, skipAt + 16'd3);
	endtask

	task automatic haltAndWake();
		logic [15:0] haltAt;
		logic        quiet;
		clearMemory();
		ldImm(`REG_A, 8'h5C);
		haltAt = cursor;
		putByte(`OP_HALT);
		storeA(16'h8300);
		expectWrite(16'h8300, 8'h5C);
		putByte(`OP_HALT);
		pulseReset();
		runUntilHalt();
		quiet = 1'b1;
		repeat (50) begin
			@(negedge CLK);
			if (rd !== 1'b0 || mreq !== 1'b0) quiet = 1'b0;
		end
		checks++;
		if (!quiet) begin
			$display("A bus read happened while the core was halted");
			errors++;
		end
		@(posedge CLK);
		wake <= 1'b1;
		@(posedge CLK);
		wake <= 1'b0;
		runUntilHalt();
		checkNextFetch(haltAt, haltAt + 16'd1);
		compareWrites();
	endtask

	task automatic unknownOpcode();
		logic [15:0] u0;
		logic [15:0] u1;
		logic [15:0] u2;
		clearMemory();
		ldImm(`REG_A, 8'h3C);
		ldImm(`REG_B, 8'h21);
		u0 = cursor;
		putByte(8'hD3);						// Not in the set.
		aluWith(`ALU_F_ADD, `REG_B);
		u1 = cursor;
		putByte(8'hE4);
		storeA(16'h8400);
		expectWrite(16'h8400, 8'h3C + 8'h21);
		u2 = cursor;
		putByte(8'hFC);
		ldReg(`REG_A, `REG_B);				// B must still hold its value.
		storeA(16'h8401);
		expectWrite(16'h8401, 8'h21);
		putByte(`OP_HALT);
		pulseReset();
		runUntilHalt();
		compareWrites();
		checkNextFetch(u0, u0 + 16'd1);
		checkNextFetch(u1, u1 + 16'd1);
		checkNextFetch(u2, u2 + 16'd1);
	endtask

	initial begin
		clearMemory();
		mem[`RESET_PC] = `OP_HALT;			// Park the core after power-on reset.
		@(negedge porReset);
		runUntilHalt();
		checkReset();
		loadsAndStores();
		aluOps();
		jumps();
		haltAndWake();
		unknownOpcode();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
sm83Pkg.sv
ctrlIf.sv
Sequencer.sv
Decoder.sv
Alu.sv
Bottom.sv
SM83Core.sv
tbClock.sv
SM83CoreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -f sim.f --top-module SM83CoreTb -o simTb
./obj_dir/simTb > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failure"
